/* Bender.yml */
package:
  name: dot_matrix_display

sources:
  - logic/dot_matrix_pkg.sv
  - logic/row_scanner.sv
  - logic/glyph_rom.sv
  - logic/matrix_driver.sv
  - logic/dot_matrix_display.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dot_matrix_display.sv

/* dot_matrix_display.f */
+incdir+tests
logic/dot_matrix_pkg.sv
logic/row_scanner.sv
logic/glyph_rom.sv
logic/matrix_driver.sv
logic/dot_matrix_display.sv
tests/tb_dot_matrix_display.sv

/* logic/dot_matrix_display.sv */
`timescale 1ns/1ns

module dot_matrix_display
    import dot_matrix_pkg::*;
#(
    parameter int SCAN_DIV = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     hot,
    input  glyph_t   glyph,
    output row_sel_t row,
    output col_t     colg,
    output col_t     colr
);

    row_idx_t row_index;
    logic     frame_start;
    glyph_t   glyph_sel;
    logic     glyph_valid;
    col_t     pixels;

    row_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) row_scanner_i (
        .clk         (clk),
        .rst         (rst),
        .row_index   (row_index),
        .frame_start (frame_start)
    );

    glyph_rom glyph_rom_i (
        .glyph_sel   (glyph_sel),
        .glyph_valid (glyph_valid),
        .row_index   (row_index),
        .pixels      (pixels)
    );

    matrix_driver matrix_driver_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .hot         (hot),
        .glyph       (glyph),
        .row_index   (row_index),
        .frame_start (frame_start),
        .pixels      (pixels),
        .glyph_sel   (glyph_sel),
        .glyph_valid (glyph_valid),
        .row         (row),
        .colg        (colg),
        .colr        (colr)
    );

endmodule

/* logic/dot_matrix_pkg.sv */
package dot_matrix_pkg;

    // field widths
    localparam int ROW_W   = 3;
    localparam int COL_W   = 8;
    localparam int GLYPH_W = 4;

    // scan geometry, square matrix
    localparam int ROW_COUNT = 8;

    // glyphs 0..GLYPH_COUNT-1 have a bitmap, the rest are blank
    localparam int GLYPH_COUNT = 8;

    // row index of the scan, 0 is the top row
    typedef logic [ROW_W-1:0] row_idx_t;

    // active-low row select, bit n low drives row n
    typedef logic [ROW_COUNT-1:0] row_sel_t;

    // column pattern, bit 7 leftmost, 1 = lit
    typedef logic [COL_W-1:0] col_t;

    // glyph number from the host
    typedef logic [GLYPH_W-1:0] glyph_t;

endpackage

/* logic/glyph_rom.sv */
`timescale 1ns/1ns

module glyph_rom
    import dot_matrix_pkg::*;
(
    input  glyph_t   glyph_sel,
    input  logic     glyph_valid,
    input  row_idx_t row_index,
    output col_t     pixels
);

    always_comb
    begin
        pixels = '0;
        if (glyph_valid && (glyph_sel < glyph_t'(GLYPH_COUNT)))
        begin
            case (glyph_sel[2:0])
                3'd0:
                begin
                    // smallest blob
                    case (row_index)
                        3'd2, 3'd5: pixels = 8'b0001_1000;
                        3'd3, 3'd4: pixels = 8'b0011_1100;
                        default:    pixels = 8'b0000_0000;
                    endcase
                end
                3'd1:
                begin
                    case (row_index)
                        3'd2, 3'd5: pixels = 8'b0011_1000;
                        3'd3, 3'd4: pixels = 8'b0111_1100;
                        default:    pixels = 8'b0000_0000;
                    endcase
                end
                3'd2:
                begin
                    case (row_index)
                        3'd2, 3'd5: pixels = 8'b0011_1100;
                        3'd3, 3'd4: pixels = 8'b0111_1110;
                        default:    pixels = 8'b0000_0000;
                    endcase
                end
                3'd3:
                begin
                    case (row_index)
                        3'd1, 3'd6:             pixels = 8'b0011_1100;
                        3'd2, 3'd3, 3'd4, 3'd5: pixels = 8'b0111_1110;
                        default:                pixels = 8'b0000_0000;
                    endcase
                end
                3'd4:
                begin
                    // fills the whole height
                    case (row_index)
                        3'd0, 3'd7: pixels = 8'b0011_1100;
                        3'd1, 3'd6: pixels = 8'b0111_1110;
                        default:    pixels = 8'b1111_1111;
                    endcase
                end
                3'd5:
                begin
                    pixels = 8'b1111_1111;
                end
                3'd6:
                begin
                    // flame, first phase
                    case (row_index)
                        3'd0: pixels = 8'b1100_0011;
                        3'd1: pixels = 8'b1110_0011;
                        3'd2: pixels = 8'b1111_0001;
                        3'd3: pixels = 8'b1110_0011;
                        3'd4: pixels = 8'b1100_0111;
                        3'd5: pixels = 8'b1110_0111;
                        3'd6: pixels = 8'b1111_0111;
                        3'd7: pixels = 8'b1111_1011;
                    endcase
                end
                3'd7:
                begin
                    // flame, second phase
                    case (row_index)
                        3'd1:    pixels = 8'b0000_0001;
                        3'd2:    pixels = 8'b1000_0001;
                        3'd3:    pixels = 8'b1100_0011;
                        3'd4:    pixels = 8'b1000_0011;
                        3'd5:    pixels = 8'b1100_0111;
                        3'd6:    pixels = 8'b1110_0111;
                        3'd7:    pixels = 8'b1111_0011;
                        default: pixels = 8'b0000_0000;
                    endcase
                end
            endcase
        end
    end

endmodule

/* logic/matrix_driver.sv */
`timescale 1ns/1ns

module matrix_driver
    import dot_matrix_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     hot,
    input  glyph_t   glyph,
    input  row_idx_t row_index,
    input  logic     frame_start,
    input  col_t     pixels,
    output glyph_t   glyph_sel,
    output logic     glyph_valid,
    output row_sel_t row,
    output col_t     colg,
    output col_t     colr
);

    glyph_t glyph_q;
    logic   valid_q;
    col_t   colg_next;

    // frame glyph, taken at frame start only
    always_ff @(posedge clk)
    begin
        if (frame_start)
        begin
            glyph_q <= glyph;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
        end
        else if (!enable)
        begin
            valid_q <= 1'b0; // drop the held glyph, wait for next frame
        end
        else if (frame_start)
        begin
            valid_q <= 1'b1;
        end
    end

    assign glyph_sel   = glyph_q;
    assign glyph_valid = valid_q;

    assign colg_next = (enable && valid_q) ? pixels : '0;

    // output stage, one clock behind the scan
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~(row_sel_t'(1) << row_index);
            colg <= colg_next;
            colr <= hot ? colg_next : '0; // red over green reads amber
        end
    end

    a_row_onehot: assert property (
        @(posedge clk)
        $countones(~row) <= 1
    ) else $error("more than one row driven");

    a_red_follows_green: assert property (
        @(posedge clk)
        (colr == colg) || (colr == '0)
    ) else $error("colr differs from colg");

endmodule

/* logic/row_scanner.sv */
`timescale 1ns/1ns

module row_scanner
    import dot_matrix_pkg::*;
#(
    parameter int SCAN_DIV = 4
) (
    input  logic     clk,
    input  logic     rst,
    output row_idx_t row_index,
    output logic     frame_start
);

    localparam int DIV_W = $clog2(SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             div_last;
    logic             row_last;

    // a single clock per row would leave no room for the output lag
    if (SCAN_DIV < 2) begin : g_div_check
        $error("row_scanner: SCAN_DIV must be 2 or more");
    end

    assign div_last = (div_cnt == DIV_W'(SCAN_DIV - 1));
    assign row_last = (row_index == row_idx_t'(ROW_COUNT - 1));

    // last clock of the bottom row
    assign frame_start = div_last && row_last;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
        end
        else if (div_last)
        begin
            div_cnt <= '0;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_index <= '0;
        end
        else if (div_last)
        begin
            row_index <= row_last ? '0 : row_index + 1'b1;
        end
    end

    // each row is held for the full divider period
    a_row_hold: assert property (
        @(posedge clk) disable iff (rst)
        !$past(div_last) |-> $stable(row_index)
    ) else $error("row_index moved before terminal count");

endmodule

/* tests/glyph_model.svh */
`ifndef GLYPH_MODEL_SVH
`define GLYPH_MODEL_SVH

// one entry per glyph, rows 0 (top) to 7, bit 7 is the leftmost column
localparam logic [7:0] GLYPH_TABLE [8][8] = '{
    '{8'h00, 8'h00, 8'h18, 8'h3c, 8'h3c, 8'h18, 8'h00, 8'h00},
    '{8'h00, 8'h00, 8'h38, 8'h7c, 8'h7c, 8'h38, 8'h00, 8'h00},
    '{8'h00, 8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h3c, 8'h00, 8'h00},
    '{8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h7e, 8'h7e, 8'h3c, 8'h00},
    '{8'h3c, 8'h7e, 8'hff, 8'hff, 8'hff, 8'hff, 8'h7e, 8'h3c},
    '{8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff},
    '{8'hc3, 8'he3, 8'hf1, 8'he3, 8'hc7, 8'he7, 8'hf7, 8'hfb}, // flame a
    '{8'h00, 8'h01, 8'h81, 8'hc3, 8'h83, 8'hc7, 8'he7, 8'hf3}  // flame b
};

// bitmap row, blank for glyph numbers 8..15
function automatic logic [7:0] expected_pixels(input logic [3:0] g, input logic [2:0] r);
    if (g >= 4'd8)
    begin
        return 8'h00;
    end
    return GLYPH_TABLE[g[2:0]][r];
endfunction

// green columns for the row being scanned
function automatic logic [7:0] expected_colg(
    input logic       en,
    input logic       held_valid,
    input logic [3:0] g,
    input logic [2:0] r
);
    if (en && held_valid)
    begin
        return expected_pixels(g, r);
    end
    return 8'h00;
endfunction

// active-low one-hot row select
function automatic logic [7:0] expected_row(input logic [2:0] r);
    logic [7:0] sel;
    sel    = 8'hff;
    sel[r] = 1'b0; // only the scanned row pulled low
    return sel;
endfunction

`endif

/* tests/tb_dot_matrix_display.sv */
`timescale 1ns/1ns

module tb_dot_matrix_display
    import dot_matrix_pkg::*;
();

    localparam int SCAN_DIV      = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int TEST_FRAMES   = 200;
    localparam int FRAME_CLOCKS  = 8 * SCAN_DIV;
    localparam int TEST_CYCLES   = TEST_FRAMES * FRAME_CLOCKS;
    localparam int MARGIN_CYCLES = 100;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    `include "glyph_model.svh"

    logic     clk;
    logic     rst;
    logic     enable;
    logic     hot;
    glyph_t   glyph;
    row_sel_t row;
    col_t     colg;
    col_t     colr;

    integer   seed;
    int       fail_count;

    // model state, mirrors the scan and the frame latch
    int         m_div;
    logic [2:0] m_row;
    logic       m_valid;
    logic [3:0] m_glyph;
    logic [7:0] exp_row;
    logic [7:0] exp_colg;
    logic [7:0] exp_colr;
    bit         seen_glyph [16];

    dot_matrix_display #(
        .SCAN_DIV (SCAN_DIV)
    ) dot_matrix_display_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .hot    (hot),
        .glyph  (glyph),
        .row    (row),
        .colg   (colg),
        .colr   (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout, the test loop did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(
        input string      name,
        input logic [7:0] expected,
        input logic [7:0] actual
    );
        fail_count++;
        $display("CHECK FAILED: %s expected %h got %h at %0t", name, expected, actual, $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    // called at the rising edge, uses the inputs held before it
    task automatic model_step();
        logic [7:0] next_colg;
        logic       fs;
        if (rst)
        begin
            m_div    = 0;
            m_row    = 3'd0;
            m_valid  = 1'b0;
            exp_row  = 8'hff;
            exp_colg = 8'h00;
            exp_colr = 8'h00;
        end
        else
        begin
            next_colg = expected_colg(enable, m_valid, m_glyph, m_row);
            exp_row   = expected_row(m_row);
            exp_colg  = next_colg;
            exp_colr  = hot ? next_colg : 8'h00;
            fs = (m_div == SCAN_DIV - 1) && (m_row == 3'd7); // last clock of row 7
            if (fs)
            begin
                m_glyph = glyph;
            end
            if (!enable)
            begin
                m_valid = 1'b0;
            end
            else if (fs)
            begin
                m_valid = 1'b1;
                seen_glyph[glyph] = 1'b1;
            end
            if (m_div == SCAN_DIV - 1)
            begin
                m_div = 0;
                m_row = m_row + 3'd1; // wraps 7 -> 0
            end
            else
            begin
                m_div++;
            end
        end
    endtask

    task automatic check_outputs();
        assert (row === exp_row) else report_mismatch("row", exp_row, row);
        assert (colg === exp_colg) else report_mismatch("colg", exp_colg, colg);
        assert (colr === exp_colr) else report_mismatch("colr", exp_colr, colr);
    endtask

    task automatic drive_random();
        logic [31:0] rnd;
        rnd = $random(seed);
        // enable mostly high, with short dark spells
        if (enable)
        begin
            if (rnd[5:0] == 6'd0)
            begin
                enable = 1'b0;
            end
        end
        else if (rnd[2:0] == 3'd0)
        begin
            enable = 1'b1;
        end
        hot = (rnd[8:7] != 2'b00);
        if (rnd[15:12] == 4'd0)
        begin
            glyph = rnd[19:16]; // lands anywhere in the frame
        end
    endtask

    initial
    begin
        int missing;
        seed       = 32'h40e2_b4a1;
        fail_count = 0;
        missing    = 0;
        m_div      = 0;
        m_row      = 3'd0;
        m_valid    = 1'b0;
        m_glyph    = 4'd0;
        exp_row    = 8'hff;
        exp_colg   = 8'h00;
        exp_colr   = 8'h00;
        rst        = 1'b1;
        enable     = 1'b0;
        hot        = 1'b0;
        glyph      = '0;

        for (int cyc = 0; cyc < RESET_CYCLES + TEST_CYCLES; cyc++)
        begin
            @(posedge clk);
            model_step();
            #1;
            check_outputs();
            #1;
            if (cyc == RESET_CYCLES - 1)
            begin
                rst = 1'b0;
            end
            if (cyc >= RESET_CYCLES - 1)
            begin
                drive_random();
            end
        end

        for (int g = 0; g < 16; g++)
        begin
            if (!seen_glyph[g])
            begin
                $display("glyph %0d was never latched with enable high", g);
                missing++;
            end
        end
        fail_count += missing;

        if (fail_count == 0)
        begin
            $display("checked %0d clocks over %0d frames", TEST_CYCLES, TEST_FRAMES);
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("SOME TESTS FAILED");
            $fatal(1, "stimulus did not reach every glyph");
        end
    end

endmodule
